// ==== Bender.yml ====
package:
  name: fifo

sources:
  - design/fifo_pkg.sv
  - design/fifo_sram_dp.sv
  - design/fifo_ptr_ctrl.sv
  - design/fifo_top.sv
  - target: simulation
    files:
      - verification/fifo_tb.sv

// ==== all.f ====
design/fifo_pkg.sv
design/fifo_sram_dp.sv
design/fifo_ptr_ctrl.sv
design/fifo_top.sv
verification/fifo_tb.sv

// ==== design/fifo_pkg.sv ====
// Shared sizes and encodings for the synchronous FIFO
package fifo_pkg;

  // Default address width, depth is 2**FIFO_ADDR_WIDTH words
  localparam int FIFO_ADDR_WIDTH = 4;

  // Default word width in bits
  localparam int FIFO_DATA_WIDTH = 8;

  // Request seen on push and pop in one cycle
  // Bit 0 is the push strobe, bit 1 the pop strobe
  typedef enum logic [1:0] {
    OP_IDLE     = 2'b00,
    OP_PUSH     = 2'b01,
    OP_POP      = 2'b10,
    OP_PUSH_POP = 2'b11
  } fifo_op_e;

  // Occupancy of the buffer
  typedef enum logic [1:0] {
    // No words held, pops are refused
    ST_EMPTY   = 2'b00,
    // Between one word and depth minus one
    ST_PARTIAL = 2'b01,
    // Every slot holds a word, pushes are refused
    ST_FULL    = 2'b10
  } fifo_state_e;

endpackage

// ==== design/fifo_ptr_ctrl.sv ====
`timescale 1ns/1ps

// Pointer controller
// Turns push and pop strobes into SRAM accesses and tracks occupancy
module fifo_ptr_ctrl
  import fifo_pkg::*;
#(
  parameter int ADDR_WIDTH = FIFO_ADDR_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  logic                  pop,
  output logic                  mem_cs,
  output logic                  mem_wr,
  output logic                  mem_rd,
  output logic [ADDR_WIDTH-1:0] mem_waddr,
  output logic [ADDR_WIDTH-1:0] mem_raddr,
  output logic                  full,
  output logic                  empty,
  output logic [ADDR_WIDTH:0]   count,
  output logic                  rdata_valid,
  output logic                  overflow,
  output logic                  underflow
);

  // Word count of a full buffer, one bit wider than the pointers
  localparam logic [ADDR_WIDTH:0] DEPTH = {1'b1, {ADDR_WIDTH{1'b0}}};

  fifo_op_e              op;
  fifo_state_e           state;
  fifo_state_e           state_next;
  logic                  push_req;
  logic                  pop_req;
  logic                  push_ok;
  logic                  pop_ok;
  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic [ADDR_WIDTH:0]   count_next;

  // Decode the two strobes into one request
  always_comb
  begin
    case ({pop, push})
      2'b01:   op = OP_PUSH;
      2'b10:   op = OP_POP;
      2'b11:   op = OP_PUSH_POP;
      default: op = OP_IDLE;
    endcase
  end

  assign push_req = (op == OP_PUSH) || (op == OP_PUSH_POP);
  assign pop_req  = (op == OP_POP) || (op == OP_PUSH_POP);

  // Acceptance judged on the state at the start of the cycle
  // A push and pop together can still lose one side at the limits
  assign push_ok = push_req && (state != ST_FULL);
  assign pop_ok  = pop_req && (state != ST_EMPTY);

  // Memory strobes follow the accepted requests only
  assign mem_wr    = push_ok;
  assign mem_rd    = pop_ok;
  assign mem_cs    = mem_wr | mem_rd;
  assign mem_waddr = wr_ptr;
  assign mem_raddr = rd_ptr;

  // Next occupancy, unchanged when both sides are accepted
  always_comb
  begin
    case ({push_ok, pop_ok})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  always_comb
  begin
    if (count_next == '0)
    begin
      state_next = ST_EMPTY;
    end
    else if (count_next == DEPTH)
    begin
      state_next = ST_FULL;
    end
    else
    begin
      state_next = ST_PARTIAL;
    end
  end

  // Pointers wrap through the whole address range
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      state  <= ST_EMPTY;
    end
    else
    begin
      if (push_ok)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count_next;
      state <= state_next;
    end
  end

  // Flags decoded from the registered state
  assign full  = (state == ST_FULL);
  assign empty = (state == ST_EMPTY);

  // One-cycle pulses in the cycle after the request
  // rdata_valid lines up with the registered SRAM output
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdata_valid <= 1'b0;
      overflow    <= 1'b0;
      underflow   <= 1'b0;
    end
    else
    begin
      rdata_valid <= pop_ok;
      overflow    <= push_req && !push_ok;
      underflow   <= pop_req && !pop_ok;
    end
  end

  // No write into a full buffer
  a_no_wr_full : assert property (
    @(posedge clk) disable iff (rst) (count == DEPTH) |-> !mem_wr
  ) else $error("SRAM write issued while full");

  // No read from an empty buffer
  a_no_rd_empty : assert property (
    @(posedge clk) disable iff (rst) (count == '0) |-> !mem_rd
  ) else $error("SRAM read issued while empty");

  // Occupancy bounded by the depth across any sequence of requests
  a_count_range : assert property (
    @(posedge clk) disable iff (rst) count <= DEPTH
  ) else $error("count %0d exceeds depth", count);

  // Flags track the count and so never rise together
  a_flags_excl : assert property (
    @(posedge clk) disable iff (rst)
      (full == (count == DEPTH)) && (empty == (count == '0))
  ) else $error("full %0b and empty %0b disagree with count %0d", full, empty, count);

endmodule

// ==== design/fifo_sram_dp.sv ====
`timescale 1ns/1ps

// Dual-port SRAM with one write port and one registered read port
module fifo_sram_dp #(
  parameter int                    ADDR_WIDTH = 4,
  parameter int                    DATA_WIDTH = 8,
  parameter int                    WRITETHRU  = 0,
  parameter logic [DATA_WIDTH-1:0] IDLE_DATA  = '1
) (
  input  logic                  clk,
  input  logic                  cs,
  input  logic                  rd,
  input  logic                  wr,
  input  logic [ADDR_WIDTH-1:0] raddr,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [DATA_WIDTH-1:0] wdata,
  output logic [DATA_WIDTH-1:0] rdata
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  // Storage array, no reset on the contents
  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Write port
  always_ff @(posedge clk)
  begin
    if (wr && cs)
    begin
      mem[waddr] <= wdata;
    end
  end

  generate
    if (WRITETHRU != 0)
    begin : g_writethru
      // Read address and read flag captured at the clock edge
      logic [ADDR_WIDTH-1:0] raddr_q;
      logic                  rd_cycle;

      always_ff @(posedge clk)
      begin
        raddr_q  <= raddr;
        rd_cycle <= rd && cs;
      end

      // Array looked up after the edge, so a same-edge write shows new data
      assign rdata = rd_cycle ? mem[raddr_q] : IDLE_DATA;
    end
    else
    begin : g_readfirst
      // Data register loaded at the edge, a same-edge write shows old data
      always_ff @(posedge clk)
      begin
        if (rd && cs)
        begin
          rdata <= mem[raddr];
        end
        else
        begin
          // Idle pattern after any cycle without a read
          rdata <= IDLE_DATA;
        end
      end
    end
  endgenerate

  // Read and write never collide on one slot, the pointer controller
  // keeps the read pointer off the slot being written
  a_no_collision : assert property (
    @(posedge clk) (cs && wr && rd) |-> (waddr != raddr)
  ) else $error("SRAM read and write hit address %0h in one cycle", waddr);

endmodule

// ==== design/fifo_top.sv ====
`timescale 1ns/1ps

// Synchronous FIFO, pointer controller in front of a dual-port SRAM
module fifo_top
  import fifo_pkg::*;
#(
  parameter int                    ADDR_WIDTH = FIFO_ADDR_WIDTH,
  parameter int                    DATA_WIDTH = FIFO_DATA_WIDTH,
  parameter int                    WRITETHRU  = 0,
  parameter logic [DATA_WIDTH-1:0] IDLE_DATA  = '1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  pop,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic                  rdata_valid,
  output logic                  full,
  output logic                  empty,
  output logic [ADDR_WIDTH:0]   count,
  output logic                  overflow,
  output logic                  underflow
);

  // Controller to SRAM strobes and addresses
  logic                  mem_cs;
  logic                  mem_wr;
  logic                  mem_rd;
  logic [ADDR_WIDTH-1:0] mem_waddr;
  logic [ADDR_WIDTH-1:0] mem_raddr;

  fifo_ptr_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .push        (push),
    .pop         (pop),
    .mem_cs      (mem_cs),
    .mem_wr      (mem_wr),
    .mem_rd      (mem_rd),
    .mem_waddr   (mem_waddr),
    .mem_raddr   (mem_raddr),
    .full        (full),
    .empty       (empty),
    .count       (count),
    .rdata_valid (rdata_valid),
    .overflow    (overflow),
    .underflow   (underflow)
  );

  // Write data goes straight in, read data straight out
  fifo_sram_dp #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .WRITETHRU  (WRITETHRU),
    .IDLE_DATA  (IDLE_DATA)
  ) u_sram (
    .clk   (clk),
    .cs    (mem_cs),
    .rd    (mem_rd),
    .wr    (mem_wr),
    .raddr (mem_raddr),
    .waddr (mem_waddr),
    .wdata (wdata),
    .rdata (rdata)
  );

endmodule

// ==== verification/fifo_tb.sv ====
`timescale 1ns/1ps

// Self-checking testbench for the synchronous FIFO
module fifo_tb
  import fifo_pkg::*;
;

  localparam int AW              = FIFO_ADDR_WIDTH;
  localparam int DW              = FIFO_DATA_WIDTH;
  localparam int DEPTH           = 1 << AW;
  localparam int CLK_PERIOD      = 40;
  localparam int WATCHDOG_CYCLES = 1500;
  localparam logic [DW-1:0] IDLE_WORD = '1;

  logic          clk;
  logic          rst;
  logic          push;
  logic          pop;
  logic [DW-1:0] wdata;
  logic [DW-1:0] rdata;
  logic          rdata_valid;
  logic          full;
  logic          empty;
  logic [AW:0]   count;
  logic          overflow;
  logic          underflow;

  // Reference model and the values the DUT should show after the coming edge
  logic [DW-1:0] ref_q[$];
  fifo_state_e   model_state;
  logic [AW:0]   exp_count;
  logic [DW-1:0] exp_data;
  logic          exp_valid;
  logic          exp_ovf;
  logic          exp_unf;
  logic          push_ok;
  logic          pop_ok;

  int errors;
  int tests_passed;
  int tests_failed;
  int errors_at_start;

  fifo_top #(
    .ADDR_WIDTH (AW),
    .DATA_WIDTH (DW),
    .WRITETHRU  (0),
    .IDLE_DATA  (IDLE_WORD)
  ) u_dut (
    .clk         (clk),
    .rst         (rst),
    .push        (push),
    .wdata       (wdata),
    .pop         (pop),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .full        (full),
    .empty       (empty),
    .count       (count),
    .overflow    (overflow),
    .underflow   (underflow)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic string state_label(fifo_state_e s);
    case (s)
      ST_EMPTY: return "ST_EMPTY";
      ST_FULL:  return "ST_FULL";
      default:  return "ST_PARTIAL";
    endcase
  endfunction

  // One mismatch line, tagged with the model occupancy
  function automatic void report_mismatch(input string name, input fifo_state_e s,
                                          input logic [31:0] exp_val,
                                          input logic [31:0] act_val);
    errors++;
    $display("[FAIL] %s in %s expected %0h got %0h", name, state_label(s), exp_val, act_val);
  endfunction

  // Inputs are stable at the falling edge, so the model predicts the next rising edge here
  always @(negedge clk)
  begin
    if (rst)
    begin
      ref_q.delete();
      {exp_valid, exp_ovf, exp_unf} = 3'b000;
      exp_data    = IDLE_WORD;
      exp_count   = '0;
      model_state = ST_EMPTY;
    end
    else
    begin
      // Both strobes judged against the occupancy before the edge
      push_ok   = push && (ref_q.size() < DEPTH);
      pop_ok    = pop && (ref_q.size() > 0);
      exp_valid = pop_ok;
      exp_ovf   = push && !push_ok;
      exp_unf   = pop && !pop_ok;
      exp_data  = pop_ok ? ref_q.pop_front() : IDLE_WORD;
      if (push_ok)
        ref_q.push_back(wdata);
      exp_count = (AW + 1)'(ref_q.size());
      if (ref_q.size() == 0)
        model_state = ST_EMPTY;
      else if (ref_q.size() == DEPTH)
        model_state = ST_FULL;
      else
        model_state = ST_PARTIAL;
    end
  end

  // Sampled DUT outputs against the prediction made one falling edge earlier
  a_count : assert property (@(negedge clk) disable iff (rst) count == exp_count)
    else report_mismatch("count", $sampled(model_state),
      32'($sampled(exp_count)), 32'($sampled(count)));
  a_full : assert property (@(negedge clk) disable iff (rst) full == (exp_count == DEPTH))
    else report_mismatch("full", $sampled(model_state),
      32'($sampled(exp_count) == DEPTH), 32'($sampled(full)));
  a_empty : assert property (@(negedge clk) disable iff (rst) empty == (exp_count == 0))
    else report_mismatch("empty", $sampled(model_state),
      32'($sampled(exp_count) == 0), 32'($sampled(empty)));
  a_valid : assert property (@(negedge clk) disable iff (rst) rdata_valid == exp_valid)
    else report_mismatch("rdata_valid", $sampled(model_state),
      32'($sampled(exp_valid)), 32'($sampled(rdata_valid)));
  // Also covers the idle pattern whenever no word is returned
  a_rdata : assert property (@(negedge clk) disable iff (rst) rdata == exp_data)
    else report_mismatch("rdata", $sampled(model_state),
      32'($sampled(exp_data)), 32'($sampled(rdata)));
  a_ovf : assert property (@(negedge clk) disable iff (rst) overflow == exp_ovf)
    else report_mismatch("overflow", $sampled(model_state),
      32'($sampled(exp_ovf)), 32'($sampled(overflow)));
  a_unf : assert property (@(negedge clk) disable iff (rst) underflow == exp_unf)
    else report_mismatch("underflow", $sampled(model_state),
      32'($sampled(exp_unf)), 32'($sampled(underflow)));

  task automatic drive(input logic do_push, input logic do_pop, input logic [DW-1:0] data);
    @(posedge clk);
    push  <= do_push;
    pop   <= do_pop;
    wdata <= data;
  endtask

  // Random request with separate push and pop percentages
  task automatic drive_random(input int push_pct, input int pop_pct);
    fifo_op_e op;
    op = fifo_op_e'({$urandom_range(0, 99) < pop_pct, $urandom_range(0, 99) < push_pct});
    drive(op == OP_PUSH || op == OP_PUSH_POP, op == OP_POP || op == OP_PUSH_POP,
      DW'($urandom()));
  endtask

  task automatic start_test();
    errors_at_start = errors;
  endtask

  // Idle cycles let the last outcomes reach the checks before the verdict
  task automatic end_test(input string name);
    repeat (3) drive(1'b0, 1'b0, '0);
    @(posedge clk);
    if (errors == errors_at_start)
    begin
      tests_passed++;
      $display("Test %s passed, model in %s", name, state_label(model_state));
    end
    else
    begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, errors - errors_at_start);
    end
  endtask

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    void'($urandom(32'h5b76));
    clk   = 1'b0;
    rst   = 1'b1;
    push  = 1'b0;
    pop   = 1'b0;
    wdata = '0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    start_test();
    end_test("reset_state");

    // Sixteen pushes fill the buffer, the seventeenth is refused
    start_test();
    repeat (DEPTH + 1) drive(1'b1, 1'b0, DW'($urandom()));
    end_test("fill_overflow");

    start_test();
    repeat (DEPTH) drive(1'b0, 1'b1, '0);
    end_test("drain_in_order");

    start_test();
    drive(1'b0, 1'b1, '0);
    end_test("underflow");

    // Push-heavy phase reaches full, pop-heavy reaches empty, then balanced
    start_test();
    repeat (200) drive_random(80, 30);
    repeat (200) drive_random(30, 80);
    repeat (400) drive_random(50, 50);
    end_test("mixed_traffic");

    $display("Tests passed: %0d, failed: %0d, assertion errors: %0d",
      tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
